/* edgeCi_defines.svh */
`ifndef EDGE_CI_DEFINES_SVH
`define EDGE_CI_DEFINES_SVH

// ====================
// instruction numbers
// ====================

// custom instruction number answered by the edge unit
`define EDGE_CI_ID 8'd20
// custom instruction number answered by the grayscale unit
`define GRAY_CI_ID 8'd21

// ====================
// window geometry
// ====================

// pixels per window row
`define WINDOW_COLS 8
// rows held in the sliding window
`define WINDOW_ROWS 3

// field positions inside valueB for the edge unit
// threshold occupies valueB[15:8]
`define THRESHOLD_LSB 8
// reverse flag, 1 selects columns 4..7 first
`define REVERSE_BIT 16

`endif

/* edgeCiPkg.sv */
package edgeCiPkg;

    // ====================
    // data types
    // ====================

    // one 8-bit grey pixel
    typedef logic [7:0] pixelT;

    // one operand or result word of a custom instruction
    typedef logic [31:0] ciWordT;

    // signed sobel gradient, range -1020..1020 fits in 11 bits
    typedef logic signed [10:0] gradientT;

    // ====================
    // edge unit commands
    // ====================

    // command code taken from valueB[7:0]
    // codes above loadLastAndRun are ignored loads
    typedef enum logic [7:0] {
        loadPx0to3     = 8'd0,
        loadPx4to7     = 8'd1,
        loadPx8to11    = 8'd2,
        loadPx12to15   = 8'd3,
        loadPx16to19   = 8'd4,
        loadLastAndRun = 8'd5
    } edgeCmdT;

endpackage

/* sobelKernel.sv */
`timescale 1ns/100ps

module sobelKernel (
    input  edgeCiPkg::pixelT pixel0,
    input  edgeCiPkg::pixelT pixel1,
    input  edgeCiPkg::pixelT pixel2,
    input  edgeCiPkg::pixelT pixel3,
    input  edgeCiPkg::pixelT pixel4,
    input  edgeCiPkg::pixelT pixel5,
    input  edgeCiPkg::pixelT pixel6,
    input  edgeCiPkg::pixelT pixel7,
    input  edgeCiPkg::pixelT pixel8,
    input  edgeCiPkg::pixelT threshold,
    output edgeCiPkg::pixelT edgeVal
);
    import edgeCiPkg::*;

    // positive and negative halves of each kernel reach at most 4*255 = 1020
    logic [9:0]  posX;
    logic [9:0]  negX;
    logic [9:0]  posY;
    logic [9:0]  negY;
    gradientT    gradX;
    gradientT    gradY;
    logic [9:0]  magX;
    logic [9:0]  magY;
    // |gx| + |gy| reaches at most 2040
    logic [10:0] magSum;

    // ====================
    // gradients
    // ====================

    // gx uses right column minus left column with the centre row weighted twice
    assign posX = 10'(pixel2) + (10'(pixel5) << 1) + 10'(pixel8);
    assign negX = 10'(pixel0) + (10'(pixel3) << 1) + 10'(pixel6);
    // gy uses bottom row minus top row with the centre column weighted twice
    assign posY = 10'(pixel6) + (10'(pixel7) << 1) + 10'(pixel8);
    assign negY = 10'(pixel0) + (10'(pixel1) << 1) + 10'(pixel2);

    assign gradX = $signed({1'b0, posX}) - $signed({1'b0, negX});
    assign gradY = $signed({1'b0, posY}) - $signed({1'b0, negY});

    // ====================
    // magnitude and threshold
    // ====================

    assign magX = gradX[10] ? 10'(-gradX) : 10'(gradX);
    assign magY = gradY[10] ? 10'(-gradY) : 10'(gradY);

    assign magSum = 11'(magX) + 11'(magY);

    // white when strictly above the threshold, black otherwise
    assign edgeVal = (magSum > 11'(threshold)) ? 8'hFF : 8'h00;

endmodule

/* edgeDetectionCi.sv */
`timescale 1ns/100ps
`include "edgeCi_defines.svh"

module edgeDetectionCi (
    input  logic              clock,
    input  logic              reset,
    input  logic              start,
    input  edgeCiPkg::ciWordT valueA,
    input  edgeCiPkg::ciWordT valueB,
    output logic              done,
    output edgeCiPkg::ciWordT result
);
    import edgeCiPkg::*;

    localparam int windowSize = `WINDOW_ROWS * `WINDOW_COLS;
    localparam int numKernels = 4;

    // window, row r column c at index r*8 + c
    pixelT      window [windowSize];
    pixelT      threshold;
    logic       reverse;
    // set for one cycle after a code-5 start
    logic       runPending;

    edgeCmdT    cmd;
    logic       isRun;
    logic       loadValid;
    logic [4:0] loadBase;
    logic [2:0] colBase;

    // kernel inputs in row-major order, and their edge outputs
    pixelT      kernelPx [numKernels][9];
    pixelT      edgePx [numKernels];

    // ====================
    // command decode
    // ====================

    assign cmd   = edgeCmdT'(valueB[7:0]);
    assign isRun = start && (cmd == loadLastAndRun);

    // first window slot written by each load code
    always_comb begin
        loadValid = 1'b1;
        loadBase  = 5'd0;
        case (cmd)
            loadPx0to3:     loadBase = 5'd0;
            loadPx4to7:     loadBase = 5'd4;
            loadPx8to11:    loadBase = 5'd8;
            loadPx12to15:   loadBase = 5'd12;
            loadPx16to19:   loadBase = 5'd16;
            loadLastAndRun: loadBase = 5'd20;
            // unknown codes load nothing but still answer
            default:        loadValid = 1'b0;
        endcase
    end

    // plain loads answer at once, the run answers from the register
    assign done = (start && !isRun) || runPending;

    // ====================
    // window registers
    // ====================

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < windowSize; i++) begin
                window[i] <= '0;
            end
            threshold  <= '0;
            reverse    <= 1'b0;
            runPending <= 1'b0;
        end else begin
            runPending <= isRun;
            if (start && loadValid) begin
                // byte b of valueA goes to pixel loadBase + b
                for (int b = 0; b < 4; b++) begin
                    window[loadBase + 5'(b)] <= valueA[8*b +: 8];
                end
            end
            if (isRun) begin
                threshold <= valueB[`THRESHOLD_LSB +: 8];
                reverse   <= valueB[`REVERSE_BIT];
            end
        end
    end

    // ====================
    // column select
    // ====================

    // forward starts at column 0, reverse at column 4
    assign colBase = reverse ? 3'd4 : 3'd0;

    // kernel k reads columns (base + k + j) mod 8, wrapping at the edge
    always_comb begin
        for (int k = 0; k < numKernels; k++) begin
            for (int r = 0; r < `WINDOW_ROWS; r++) begin
                for (int j = 0; j < 3; j++) begin
                    kernelPx[k][3*r + j] =
                        window[r*`WINDOW_COLS + ((int'(colBase) + k + j) % `WINDOW_COLS)];
                end
            end
        end
    end

    // ====================
    // kernels
    // ====================

    for (genvar k = 0; k < numKernels; k++) begin : kernelGen
        sobelKernel kernel_i (
            .pixel0   (kernelPx[k][0]),
            .pixel1   (kernelPx[k][1]),
            .pixel2   (kernelPx[k][2]),
            .pixel3   (kernelPx[k][3]),
            .pixel4   (kernelPx[k][4]),
            .pixel5   (kernelPx[k][5]),
            .pixel6   (kernelPx[k][6]),
            .pixel7   (kernelPx[k][7]),
            .pixel8   (kernelPx[k][8]),
            .threshold(threshold),
            .edgeVal  (edgePx[k])
        );
    end

    // kernel k drives result byte k
    assign result = {edgePx[3], edgePx[2], edgePx[1], edgePx[0]};

endmodule

/* grayscaleCi.sv */
`timescale 1ns/100ps

module grayscaleCi (
    input  logic              clock,
    input  logic              reset,
    input  logic              start,
    input  edgeCiPkg::ciWordT valueA,
    output logic              done,
    output edgeCiPkg::ciWordT result
);
    import edgeCiPkg::*;

    pixelT  gray0;
    pixelT  gray1;
    ciWordT resultReg;
    logic   doneReg;

    // ====================
    // rgb565 to grey
    // ====================

    // channels widened to 8 bits by repeating their top bits,
    // then weighted 77/150/29 out of 256
    function automatic pixelT rgbToGray(input logic [15:0] rgb);
        logic [7:0]  red;
        logic [7:0]  green;
        logic [7:0]  blue;
        logic [15:0] luma;
        red   = {rgb[15:11], rgb[15:13]};
        green = {rgb[10:5], rgb[10:9]};
        blue  = {rgb[4:0], rgb[4:2]};
        // weights sum to 256 so luma never exceeds 16 bits
        luma  = 16'd77 * 16'(red) + 16'd150 * 16'(green) + 16'd29 * 16'(blue);
        return luma[15:8];
    endfunction

    // pixel 0 in the low half, pixel 1 in the high half
    assign gray0 = rgbToGray(valueA[15:0]);
    assign gray1 = rgbToGray(valueA[31:16]);

    // ====================
    // result register
    // ====================

    always_ff @(posedge clock) begin
        if (reset) begin
            resultReg <= '0;
            doneReg   <= 1'b0;
        end else begin
            doneReg <= start;
            // result holds its last value between instructions
            if (start) begin
                resultReg <= {16'h0000, gray1, gray0};
            end
        end
    end

    assign done   = doneReg;
    assign result = resultReg;

endmodule

/* ciDispatcher.sv */
`timescale 1ns/100ps
`include "edgeCi_defines.svh"

module ciDispatcher (
    // processor side
    input  logic              start,
    input  logic [7:0]        ciN,
    // answers from the units
    input  logic              edgeDone,
    input  edgeCiPkg::ciWordT edgeResult,
    input  logic              grayDone,
    input  edgeCiPkg::ciWordT grayResult,
    // per-unit starts
    output logic              edgeStart,
    output logic              grayStart,
    // merged answer to the processor
    output logic              done,
    output edgeCiPkg::ciWordT result
);
    import edgeCiPkg::*;

    logic   isEdge;
    logic   isGray;
    logic   unknownDone;
    ciWordT selResult;

    // ====================
    // instruction decode
    // ====================

    assign isEdge = (ciN == `EDGE_CI_ID);
    assign isGray = (ciN == `GRAY_CI_ID);

    // a unit only ever sees its own start pulse
    assign edgeStart = start && isEdge;
    assign grayStart = start && isGray;

    // unknown numbers answer in the start cycle so the
    // processor never waits on an instruction nobody owns
    assign unknownDone = start && !isEdge && !isGray;

    // ====================
    // answer merge
    // ====================

    // only one unit can be busy at a time, since the processor
    // waits for done before the next start
    assign done = edgeDone || grayDone || unknownDone;

    // result of whichever unit answers, zero otherwise,
    // which also covers the unknown-instruction answer
    always_comb begin
        if (edgeDone) begin
            selResult = edgeResult;
        end else if (grayDone) begin
            selResult = grayResult;
        end else begin
            selResult = '0;
        end
    end

    assign result = selResult;

endmodule

/* imageCiTop.sv */
`timescale 1ns/100ps

module imageCiTop (
    input  logic              clock,
    input  logic              reset,
    // custom instruction port of the processor
    input  logic              start,
    input  logic [7:0]        ciN,
    input  edgeCiPkg::ciWordT valueA,
    input  edgeCiPkg::ciWordT valueB,
    output logic              done,
    output edgeCiPkg::ciWordT result
);
    import edgeCiPkg::*;

    // per-unit start pulses from the decoder
    logic   edgeStart;
    logic   grayStart;

    // per-unit answers back to the merge
    logic   edgeDone;
    ciWordT edgeResult;
    logic   grayDone;
    ciWordT grayResult;

    // ====================
    // dispatcher
    // ====================

    ciDispatcher dispatcher_i (
        .start     (start),
        .ciN       (ciN),
        .edgeDone  (edgeDone),
        .edgeResult(edgeResult),
        .grayDone  (grayDone),
        .grayResult(grayResult),
        .edgeStart (edgeStart),
        .grayStart (grayStart),
        .done      (done),
        .result    (result)
    );

    // ====================
    // instruction units
    // ====================

    // operands go to both units unchanged
    edgeDetectionCi edge_i (
        .clock (clock),
        .reset (reset),
        .start (edgeStart),
        .valueA(valueA),
        .valueB(valueB),
        .done  (edgeDone),
        .result(edgeResult)
    );

    // grayscale needs only valueA
    grayscaleCi gray_i (
        .clock (clock),
        .reset (reset),
        .start (grayStart),
        .valueA(valueA),
        .done  (grayDone),
        .result(grayResult)
    );

endmodule

/* imageCiTopTb.sv */
`timescale 1ns/100ps
`include "edgeCi_defines.svh"

module imageCiTopTb;
    import edgeCiPkg::*;

    logic       clock = 1'b0;
    logic       reset = 1'b1;
    logic       start = 1'b0;
    logic [7:0] ciN = 8'd0;
    ciWordT     valueA = '0;
    ciWordT     valueB = '0;
    logic       done;
    ciWordT     result;

    // stimulus table with one row per instruction and its expected answer
    logic [7:0] tabCiN [$];
    ciWordT     tabA [$];
    ciWordT     tabB [$];
    int         tabLat [$];
    ciWordT     tabExp [$];

    // model of the edge unit's window, threshold and direction
    pixelT      modelWin [24];
    pixelT      modelThr;
    bit         modelRev;

    integer     seed = 32'h8c10_4a2e;
    int         valueErrors = 0;
    int         protocolErrors = 0;
    int         cycleCount = 0;
    int         cycleLimit = 50;

    imageCiTop dut_i (
        .clock (clock),
        .reset (reset),
        .start (start),
        .ciN   (ciN),
        .valueA(valueA),
        .valueB(valueB),
        .done  (done),
        .result(result)
    );

    // 4 ns period
    always #2 clock = ~clock;
    always @(posedge clock) cycleCount <= cycleCount + 1;

    // ====================
    // reference model
    // ====================

    // four thresholded sobel pixels from the model window
    function automatic ciWordT edgeModel();
        ciWordT   res;
        int       p [9];
        int       col;
        int       mag;
        gradientT gx;
        gradientT gy;
        res = '0;
        for (int k = 0; k < 4; k++) begin
            for (int i = 0; i < 9; i++) begin
                // i walks the 3x3 window row by row, columns wrap at 8
                col  = ((modelRev ? 4 : 0) + k + i % 3) % `WINDOW_COLS;
                p[i] = int'(modelWin[(i / 3) * `WINDOW_COLS + col]);
            end
            gx  = gradientT'((p[2] + 2 * p[5] + p[8]) - (p[0] + 2 * p[3] + p[6]));
            gy  = gradientT'((p[6] + 2 * p[7] + p[8]) - (p[0] + 2 * p[1] + p[2]));
            mag = (gx < 0 ? -int'(gx) : int'(gx)) + (gy < 0 ? -int'(gy) : int'(gy));
            if (mag > int'(modelThr)) begin
                res[8*k +: 8] = 8'hFF;
            end
        end
        return res;
    endfunction

    // rgb565 to grey with channels widened by repeating their high bits
    function automatic pixelT grayOf(input logic [15:0] px);
        int red;
        int green;
        int blue;
        red   = (int'(px[15:11]) << 3) | (int'(px[15:11]) >> 2);
        green = (int'(px[10:5]) << 2) | (int'(px[10:5]) >> 4);
        blue  = (int'(px[4:0]) << 3) | (int'(px[4:0]) >> 2);
        return pixelT'((77 * red + 150 * green + 29 * blue) >> 8);
    endfunction

    // current last four pixels so a rerun keeps the window
    function automatic ciWordT lastSlice();
        return {modelWin[23], modelWin[22], modelWin[21], modelWin[20]};
    endfunction

    // ====================
    // table building
    // ====================

    task automatic pushEntry(input logic [7:0] n, input ciWordT a, input ciWordT b,
                             input int lat, input ciWordT expResult);
        tabCiN.push_back(n);
        tabA.push_back(a);
        tabB.push_back(b);
        tabLat.push_back(lat);
        tabExp.push_back(expResult);
    endtask

    task automatic addEdge(input logic [7:0] code, input ciWordT a, input pixelT thr,
                           input bit rev);
        ciWordT b;
        ciWordT expResult;
        b = ciWordT'(code) | (ciWordT'(thr) << `THRESHOLD_LSB)
            | (ciWordT'(rev) << `REVERSE_BIT);
        if (code == 8'd5) begin
            // run answers after the last slice and settings are in
            for (int i = 0; i < 4; i++) begin
                modelWin[20 + i] = a[8*i +: 8];
            end
            modelThr  = thr;
            modelRev  = rev;
            expResult = edgeModel();
            pushEntry(`EDGE_CI_ID, a, b, 1, expResult);
        end else begin
            // plain load shows the window as it was before the load
            expResult = edgeModel();
            if (code < 8'd5) begin
                for (int i = 0; i < 4; i++) begin
                    modelWin[int'(code) * 4 + i] = a[8*i +: 8];
                end
            end
            pushEntry(`EDGE_CI_ID, a, b, 0, expResult);
        end
    endtask

    task automatic addGray(input ciWordT a);
        pushEntry(`GRAY_CI_ID, a, ciWordT'($random(seed)), 1,
                  {16'h0000, grayOf(a[31:16]), grayOf(a[15:0])});
    endtask

    // valueB code 0 would clobber pixels 0..3 if misrouted to the edge unit
    task automatic addUnknown(input logic [7:0] n, input ciWordT a);
        pushEntry(n, a, '0, 0, '0);
    endtask

    // six loads of one random window
    task automatic loadRandomWindow(input ciWordT mask);
        pixelT thr;
        bit    rev;
        thr = pixelT'($random(seed));
        rev = 1'($random(seed));
        for (int c = 0; c < 6; c++) begin
            addEdge(8'(c), ciWordT'($random(seed)) & mask, thr, rev);
        end
    endtask

    // ====================
    // checking
    // ====================

    task automatic checkValue(input ciWordT expected, input ciWordT actual, input string msg);
        if (expected !== actual) begin
            $display("[FAIL] %0t: %s, expected %h, got %h", $time, msg, expected, actual);
            valueErrors++;
        end
    endtask

    // one start pulse, then step cycle by cycle until done
    task automatic runEntry(input int idx);
        int waited;
        @(posedge clock);
        start  <= 1'b1;
        ciN    <= tabCiN[idx];
        valueA <= tabA[idx];
        valueB <= tabB[idx];
        waited = 0;
        @(negedge clock);
        while (done !== 1'b1 && waited < 4) begin
            @(posedge clock);
            start <= 1'b0;
            waited++;
            @(negedge clock);
        end
        if (done !== 1'b1) begin
            $display("entry %0d never answered with done after its start", idx);
            protocolErrors++;
        end else begin
            checkValue(tabLat[idx], waited, $sformatf("entry %0d latency", idx));
            checkValue(tabExp[idx], result, $sformatf("entry %0d result", idx));
        end
        @(posedge clock);
        start <= 1'b0;
        @(negedge clock);
        // done is a single pulse per instruction
        if (done !== 1'b0) begin
            $display("entry %0d: done stayed high a cycle after its answer", idx);
            protocolErrors++;
        end
    endtask

    // hang guard sized from the table length
    initial begin
        @(posedge clock);
        while (cycleCount < cycleLimit) begin
            @(posedge clock);
        end
        $display("timeout: table not finished after %0d cycles", cycleLimit);
        protocolErrors++;
        $display("errors: %0d value, %0d protocol", valueErrors, protocolErrors);
        $display("Errors found");
        $finish;
    end

    // ====================
    // main sequence
    // ====================

    initial begin
        for (int i = 0; i < 24; i++) begin
            modelWin[i] = '0;
        end
        modelThr = '0;
        modelRev = 1'b0;
        // all-zero window after reset gives a zero run
        addEdge(8'd5, 32'h0000_0000, 8'd0, 1'b0);
        // dark left half and bright right half
        // bottom row brighter on the left and darker on the right
        addEdge(8'd0, 32'h1010_1010, 8'd0, 1'b0);
        addEdge(8'd1, 32'hF0F0_F0F0, 8'd0, 1'b0);
        addEdge(8'd2, 32'h1010_1010, 8'd0, 1'b0);
        addEdge(8'd3, 32'hF0F0_F0F0, 8'd0, 1'b0);
        addEdge(8'd4, 32'h2020_2020, 8'd0, 1'b0);
        // code 7 loads nothing so the window stays as is
        addEdge(8'd7, 32'hDEAD_BEEF, 8'd0, 1'b0);
        addEdge(8'd5, 32'hC0C0_C0C0, 8'd100, 1'b0);
        // reverse columns, then threshold only
        addEdge(8'd5, 32'hC0C0_C0C0, 8'd100, 1'b1);
        addEdge(8'd5, 32'hC0C0_C0C0, 8'd40, 1'b1);
        addEdge(8'd5, 32'hC0C0_C0C0, 8'd255, 1'b1);
        // masked windows keep gradients near the threshold range
        for (int w = 0; w < 10; w++) begin
            loadRandomWindow(w[0] ? 32'h1F1F_1F1F : 32'hFFFF_FFFF);
        end
        // white/black, red/green, blue/mid grey
        addGray(32'hFFFF_0000);
        addGray(32'hF800_07E0);
        addGray(32'h001F_8410);
        repeat (6) begin
            addGray(ciWordT'($random(seed)));
        end
        // edge window must survive the grayscale traffic
        addEdge(8'd5, lastSlice(), modelThr, modelRev);
        addUnknown(8'd0, ciWordT'($random(seed)));
        addUnknown(8'd19, ciWordT'($random(seed)));
        addUnknown(8'd22, ciWordT'($random(seed)));
        addUnknown(8'hFF, ciWordT'($random(seed)));
        addEdge(8'd5, lastSlice(), modelThr, modelRev);
        addGray(32'h7BEF_39E7);
        cycleLimit = 20 * tabCiN.size() + 50;

        repeat (3) @(posedge clock);
        reset <= 1'b0;
        // idle after reset where nothing may answer
        repeat (5) begin
            @(negedge clock);
            if (done !== 1'b0) begin
                $display("done went high after reset with no instruction issued");
                protocolErrors++;
            end
        end
        for (int i = 0; i < tabCiN.size(); i++) begin
            runEntry(i);
        end

        $display("errors: %0d value, %0d protocol", valueErrors, protocolErrors);
        if (valueErrors + protocolErrors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* imageCiTop.f */
+incdir+.
edgeCiPkg.sv
sobelKernel.sv
edgeDetectionCi.sv
grayscaleCi.sv
ciDispatcher.sv
imageCiTop.sv
imageCiTopTb.sv

/* runSim.sh */
#!/bin/sh
# build the imageCiTop testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log build.log

verilator --binary --timing -Wno-fatal -f imageCiTop.f --top-module imageCiTopTb \
    -o imageCiTopSim > build.log 2>&1 ||
    { echo "build failed, see build.log"; exit 1; }

./obj_dir/imageCiTopSim > sim.log 2>&1 ||
    { echo "simulation did not complete, see sim.log"; exit 1; }

grep -q "Errors found" sim.log &&
    { echo "simulation FAILED, see sim.log"; exit 1; }

echo "simulation PASSED"
